/* hw/dircc_pkg.sv */
package dircc_pkg;

    localparam int MEM_WIDTH           = 16;
    localparam int ADDRESS_WIDTH       = 15;
    localparam int BYTE_WIDTH          = 8;
    localparam int REGION_BYTES        = 12;              // populated bytes per region
    localparam int DEV_MEM_BYTES       = REGION_BYTES;
    localparam int EDGE_MEM_BYTES      = REGION_BYTES;
    localparam int EDGE_COUNT          = 6;
    localparam int EDGE_INDEX_WIDTH    = 3;
    localparam int LOCAL_ADDRESS_WIDTH = 4;               // 16-byte regions
    localparam int USER_STATE_WIDTH    = 64;

    localparam logic [ADDRESS_WIDTH-1:0] STATUS_BASE = 15'd0;
    localparam logic [ADDRESS_WIDTH-1:0] EDGE_BASE   = 15'd16;

    localparam logic [MEM_WIDTH-1:0] DIRCC_RUNNING = 16'd1;

    typedef logic [REGION_BYTES*BYTE_WIDTH-1:0] region_t;

    // byte 0 is the lsb, so this matches the status register byte order
    typedef struct packed {
        logic [USER_STATE_WIDTH-1:0] user_state;          // bytes 4..11
        logic [MEM_WIDTH-1:0]        extra_state;         // bytes 2..3
        logic [MEM_WIDTH-1:0]        dircc_state;         // bytes 0..1
    } dircc_state_t;

    typedef struct packed {
        logic [EDGE_INDEX_WIDTH-1:0] edge_index;
        logic [MEM_WIDTH-1:0]        value;
    } dircc_msg_t;

    typedef struct packed {
        logic [LOCAL_ADDRESS_WIDTH-1:0] address;          // byte index in region
        logic [MEM_WIDTH-1:0]           data;
        logic                           write;
    } host_write_t;

    // low byte at address, high byte at address+1, bytes past the region dropped
    function automatic region_t region_write(region_t mem, host_write_t wr);
        region_t                      result;
        logic [LOCAL_ADDRESS_WIDTH:0] high_index;
        result     = mem;
        high_index = {1'b0, wr.address} + 1'b1;
        if (wr.write) begin
            if (wr.address < REGION_BYTES)
                result[wr.address*BYTE_WIDTH +: BYTE_WIDTH] = wr.data[BYTE_WIDTH-1:0];
            if (high_index < REGION_BYTES)
                result[high_index*BYTE_WIDTH +: BYTE_WIDTH] = wr.data[MEM_WIDTH-1:BYTE_WIDTH];
        end
        return result;
    endfunction

    function automatic logic [MEM_WIDTH-1:0] region_read(
        region_t                        mem,
        logic [LOCAL_ADDRESS_WIDTH-1:0] address
    );
        logic [MEM_WIDTH-1:0]         word;
        logic [LOCAL_ADDRESS_WIDTH:0] high_index;
        word       = '0;
        high_index = {1'b0, address} + 1'b1;
        if (address < REGION_BYTES)
            word[BYTE_WIDTH-1:0] = mem[address*BYTE_WIDTH +: BYTE_WIDTH];
        if (high_index < REGION_BYTES)
            word[MEM_WIDTH-1:BYTE_WIDTH] = mem[high_index*BYTE_WIDTH +: BYTE_WIDTH];
        return word;
    endfunction

endpackage : dircc_pkg

/* hw/dircc_status_register.sv */
`timescale 1ns/100ps

module dircc_status_register
    import dircc_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,

    input  host_write_t          status_write,
    output logic [MEM_WIDTH-1:0] status_readdata,

    output dircc_state_t         state,
    input  dircc_state_t         write_state,
    input  logic                 write_state_valid
);

    logic [DEV_MEM_BYTES*BYTE_WIDTH-1:0] dev_mem;         // byte i at bits 8i+7..8i

    // struct packing lines up with the byte layout directly
    assign state = dircc_state_t'(dev_mem);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dev_mem         <= '0;
            status_readdata <= '0;
        end else begin
            if (write_state_valid) begin
                dev_mem <= write_state;                   // engine wins over host
            end else begin
                dev_mem <= region_write(dev_mem, status_write);
            end
            status_readdata <= region_read(dev_mem, status_write.address);
        end
    end

endmodule : dircc_status_register

/* hw/dircc_edge_memory.sv */
`timescale 1ns/100ps

module dircc_edge_memory
    import dircc_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_n,

    input  host_write_t                 edge_write,
    output logic [MEM_WIDTH-1:0]        edge_readdata,

    input  logic [EDGE_INDEX_WIDTH-1:0] edge_index,
    output logic [MEM_WIDTH-1:0]        edge_weight
);

    logic [EDGE_MEM_BYTES*BYTE_WIDTH-1:0] weights;        // weight k in bytes 2k, 2k+1

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            weights       <= '0;
            edge_readdata <= '0;
        end else begin
            weights       <= region_write(weights, edge_write);
            edge_readdata <= region_read(weights, edge_write.address);
        end
    end

    // engine lookup with no edge behind indexes 6 and 7
    always_comb begin
        if (edge_index < EDGE_COUNT) begin
            edge_weight = weights[edge_index*MEM_WIDTH +: MEM_WIDTH];
        end else begin
            edge_weight = '0;
        end
    end

endmodule : dircc_edge_memory

/* hw/dircc_host_port.sv */
`timescale 1ns/100ps

module dircc_host_port
    import dircc_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic [ADDRESS_WIDTH-1:0] mem_address,
    input  logic                     mem_write,
    input  logic [MEM_WIDTH-1:0]     mem_writedata,
    output logic [MEM_WIDTH-1:0]     mem_readdata,

    output host_write_t              status_write,
    output host_write_t              edge_write,
    input  logic [MEM_WIDTH-1:0]     status_readdata,
    input  logic [MEM_WIDTH-1:0]     edge_readdata
);

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_STATUS,
        REGION_EDGE
    } region_sel_t;

    logic [ADDRESS_WIDTH-LOCAL_ADDRESS_WIDTH-1:0] region_page;
    logic [LOCAL_ADDRESS_WIDTH-1:0]               local_address;
    region_sel_t                                  region;
    region_sel_t                                  region_q;   // region of last cycle's read

    assign region_page   = mem_address[ADDRESS_WIDTH-1:LOCAL_ADDRESS_WIDTH];
    assign local_address = mem_address[LOCAL_ADDRESS_WIDTH-1:0];

    always_comb begin
        if (region_page == STATUS_BASE[ADDRESS_WIDTH-1:LOCAL_ADDRESS_WIDTH]) begin
            region = REGION_STATUS;
        end else if (region_page == EDGE_BASE[ADDRESS_WIDTH-1:LOCAL_ADDRESS_WIDTH]) begin
            region = REGION_EDGE;
        end else begin
            region = REGION_NONE;
        end
    end

    // both regions see the address, only one gets the strobe
    assign status_write = '{address: local_address, data: mem_writedata,
                            write: mem_write && (region == REGION_STATUS)};
    assign edge_write   = '{address: local_address, data: mem_writedata,
                            write: mem_write && (region == REGION_EDGE)};

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            region_q <= REGION_NONE;
        end else begin
            region_q <= region;
        end
    end

    always_comb begin
        case (region_q)
            REGION_STATUS: mem_readdata = status_readdata;
            REGION_EDGE:   mem_readdata = edge_readdata;
            default:       mem_readdata = '0;       // unmapped reads as zero
        endcase
    end

endmodule : dircc_host_port

/* hw/dircc_update_engine.sv */
`timescale 1ns/100ps

module dircc_update_engine
    import dircc_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_n,

    input  logic                        msg_valid,
    input  dircc_msg_t                  msg,
    input  dircc_state_t                state,

    output logic [EDGE_INDEX_WIDTH-1:0] edge_index,
    input  logic [MEM_WIDTH-1:0]        edge_weight,

    output dircc_state_t                write_state,
    output logic                        write_state_valid
);

    dircc_state_t           fwd_state;
    dircc_state_t           next_state;
    logic                   accept;
    logic                   s1_valid;
    logic [MEM_WIDTH-1:0]   s1_value;
    logic [MEM_WIDTH-1:0]   s1_weight;
    logic [2*MEM_WIDTH-1:0] product;

    // status register only catches up one edge after write_state_valid,
    // so the pending result stands in for it during that cycle
    assign fwd_state = write_state_valid ? write_state : state;

    assign edge_index = msg.edge_index;               // weight comes back same cycle
    assign accept     = msg_valid && (fwd_state.dircc_state == DIRCC_RUNNING);

    assign product = s1_value * s1_weight;

    always_comb begin
        next_state             = fwd_state;           // dircc_state passes through
        next_state.user_state  = fwd_state.user_state
                               + {{(USER_STATE_WIDTH-2*MEM_WIDTH){1'b0}}, product};
        next_state.extra_state = fwd_state.extra_state + 16'd1;   // message count
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid          <= 1'b0;
            write_state_valid <= 1'b0;
        end else begin
            s1_valid          <= accept;
            write_state_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_value  <= msg.value;
            s1_weight <= edge_weight;
        end
        if (s1_valid) begin
            write_state <= next_state;
        end
    end

endmodule : dircc_update_engine

/* hw/dircc_node.sv */
`timescale 1ns/100ps

module dircc_node
    import dircc_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic [ADDRESS_WIDTH-1:0] mem_address,
    input  logic                     mem_write,
    input  logic [MEM_WIDTH-1:0]     mem_writedata,
    output logic [MEM_WIDTH-1:0]     mem_readdata,

    input  logic                     msg_valid,
    input  dircc_msg_t               msg
);

    host_write_t                 status_write;
    host_write_t                 edge_write;
    logic [MEM_WIDTH-1:0]        status_readdata;
    logic [MEM_WIDTH-1:0]        edge_readdata;
    dircc_state_t                state;
    dircc_state_t                write_state;
    logic                        write_state_valid;
    logic [EDGE_INDEX_WIDTH-1:0] edge_index;
    logic [MEM_WIDTH-1:0]        edge_weight;

    dircc_host_port u_host_port (
        .clk             (clk),
        .reset_n         (reset_n),
        .mem_address     (mem_address),
        .mem_write       (mem_write),
        .mem_writedata   (mem_writedata),
        .mem_readdata    (mem_readdata),
        .status_write    (status_write),
        .edge_write      (edge_write),
        .status_readdata (status_readdata),
        .edge_readdata   (edge_readdata)
    );

    dircc_status_register u_status_register (
        .clk               (clk),
        .reset_n           (reset_n),
        .status_write      (status_write),
        .status_readdata   (status_readdata),
        .state             (state),
        .write_state       (write_state),
        .write_state_valid (write_state_valid)
    );

    dircc_edge_memory u_edge_memory (
        .clk           (clk),
        .reset_n       (reset_n),
        .edge_write    (edge_write),
        .edge_readdata (edge_readdata),
        .edge_index    (edge_index),
        .edge_weight   (edge_weight)
    );

    dircc_update_engine u_update_engine (
        .clk               (clk),
        .reset_n           (reset_n),
        .msg_valid         (msg_valid),
        .msg               (msg),
        .state             (state),
        .edge_index        (edge_index),
        .edge_weight       (edge_weight),
        .write_state       (write_state),
        .write_state_valid (write_state_valid)
    );

endmodule : dircc_node

/* testbench/tb_dircc_node.sv */
`timescale 1ns/100ps

module tb_dircc_node
    import dircc_pkg::*;
;

    localparam int DRAIN_CYCLES = 4;                      // message pipeline depth plus margin
    localparam int POLL_LIMIT   = 40;

    logic                     clk = 1'b0;
    logic                     reset_n;
    logic [ADDRESS_WIDTH-1:0] mem_address;
    logic                     mem_write;
    logic [MEM_WIDTH-1:0]     mem_writedata;
    logic [MEM_WIDTH-1:0]     mem_readdata;
    logic                     msg_valid;
    dircc_msg_t               msg;

    logic [MEM_WIDTH-1:0]        exp_weight [0:7];        // 6 and 7 stay zero
    logic [USER_STATE_WIDTH-1:0] exp_user;
    logic [MEM_WIDTH-1:0]        exp_extra;
    logic [MEM_WIDTH-1:0]        exp_dircc;
    int                          value_errors = 0;
    int                          timeouts     = 0;

    dircc_node UUT (
        .clk           (clk),
        .reset_n       (reset_n),
        .mem_address   (mem_address),
        .mem_write     (mem_write),
        .mem_writedata (mem_writedata),
        .mem_readdata  (mem_readdata),
        .msg_valid     (msg_valid),
        .msg           (msg)
    );

    always #2 clk = ~clk;

    // all bus tasks start and end on a falling edge
    task automatic read_word(input logic [ADDRESS_WIDTH-1:0] addr, output logic [15:0] data);
        mem_address = addr;
        mem_write   = 1'b0;
        @(negedge clk);
        data = mem_readdata;                              // one cycle after the address
    endtask

    task automatic write_word(input logic [ADDRESS_WIDTH-1:0] addr, input logic [15:0] data);
        mem_address   = addr;
        mem_writedata = data;
        mem_write     = 1'b1;
        @(negedge clk);
        mem_write     = 1'b0;
    endtask

    task automatic check_word(input logic [ADDRESS_WIDTH-1:0] addr, input logic [15:0] expected);
        logic [15:0] data;
        read_word(addr, data);
        assert (data === expected) else begin
            $display("error at time %0t: mem_readdata at address %h got %h expected %h",
                     $time, addr, data, expected);
            value_errors++;
        end
    endtask

    task automatic check_state();
        check_word(STATUS_BASE + 0, exp_dircc);
        check_word(STATUS_BASE + 2, exp_extra);
        for (int w = 0; w < 4; w++)
            check_word(STATUS_BASE + 4 + 2*w, exp_user[16*w +: 16]);
        check_word(STATUS_BASE + 12, 16'h0);              // unpopulated bytes
        check_word(STATUS_BASE + 14, 16'h0);
    endtask

    task automatic check_weights();
        for (int k = 0; k < 8; k++)
            check_word(EDGE_BASE + 2*k, (k < EDGE_COUNT) ? exp_weight[k] : 16'h0);
    endtask

    task automatic set_state(input logic [15:0] dircc, input logic [15:0] extra,
                             input logic [63:0] user);
        for (int w = 0; w < 4; w++)
            write_word(STATUS_BASE + 4 + 2*w, user[16*w +: 16]);
        write_word(STATUS_BASE + 2, extra);
        write_word(STATUS_BASE + 0, dircc);               // written last so the node starts set up
        exp_user  = user;
        exp_extra = extra;
        exp_dircc = dircc;
    endtask

    task automatic apply_model(input logic [2:0] edge_sel, input logic [15:0] value);
        if (exp_dircc == DIRCC_RUNNING) begin
            exp_user  = exp_user + {48'h0, value} * {48'h0, exp_weight[edge_sel]};
            exp_extra = exp_extra + 16'd1;
        end
    endtask

    // drives one message per call, back to back when called in a row
    task automatic drive_msg(input logic [2:0] edge_sel, input logic [15:0] value);
        msg_valid      = 1'b1;
        msg.edge_index = edge_sel;
        msg.value      = value;
        apply_model(edge_sel, value);
        @(negedge clk);
    endtask

    task automatic end_msgs();
        msg_valid = 1'b0;
    endtask

    task automatic drain_pipeline();
        for (int c = 0; c < DRAIN_CYCLES; c++)
            @(negedge clk);
    endtask

    task automatic wait_for_count(input logic [15:0] count);
        logic [15:0] data;
        int          polls;
        polls = 0;
        read_word(STATUS_BASE + 2, data);
        while (data !== count && polls < POLL_LIMIT) begin
            read_word(STATUS_BASE + 2, data);
            polls++;
        end
        if (data !== count) begin
            $display("timeout: message count never reached %0d, last read %0d", count, data);
            timeouts++;
        end
    endtask

    initial begin
        void'($urandom(32'h3939));
        reset_n       = 1'b0;
        mem_address   = '0;
        mem_write     = 1'b0;
        mem_writedata = '0;
        msg_valid     = 1'b0;
        msg           = '0;
        exp_user      = '0;
        exp_extra     = '0;
        exp_dircc     = '0;
        for (int k = 0; k < 8; k++)
            exp_weight[k] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        for (int a = 0; a < 32; a += 2)                   // both regions clear after reset
            check_word(a, 16'h0);

        for (int k = 0; k < EDGE_COUNT; k++) begin
            exp_weight[k] = 16'($urandom);
            write_word(EDGE_BASE + 2*k, exp_weight[k]);
        end
        set_state(16'h00a5, 16'($urandom), {$urandom, $urandom});
        write_word(EDGE_BASE + 12, 16'hbeef);             // past the six weights
        write_word(EDGE_BASE + 14, 16'hbeef);
        write_word(STATUS_BASE + 12, 16'hcafe);
        write_word(STATUS_BASE + 14, 16'hcafe);
        write_word(15'd32, 16'h1234);                     // unmapped
        write_word(15'h7ff2, 16'h5678);
        check_word(15'd32, 16'h0);
        check_word(15'h4010, 16'h0);
        check_word(15'h7ff2, 16'h0);
        check_weights();
        check_state();

        for (int i = 0; i < 4; i++)                       // stopped node drops these
            drive_msg(3'(i), 16'($urandom));
        end_msgs();
        drain_pipeline();
        check_state();

        write_word(STATUS_BASE + 0, DIRCC_RUNNING);
        exp_dircc = DIRCC_RUNNING;
        for (int i = 0; i < 12; i++) begin                // isolated messages over every edge index
            drive_msg(3'(i), 16'($urandom));
            end_msgs();
            wait_for_count(exp_extra);
            check_state();
        end

        for (int i = 0; i < 16; i++)                      // burst exercises forwarding
            drive_msg(3'($urandom), 16'($urandom));
        end_msgs();
        wait_for_count(exp_extra);
        check_state();

        write_word(STATUS_BASE + 0, 16'h0);
        exp_dircc = 16'h0;
        for (int i = 0; i < 6; i++)
            drive_msg(3'($urandom), 16'($urandom));
        end_msgs();
        drain_pipeline();
        check_state();
        check_weights();

        $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_dircc_node

/* src.f */
hw/dircc_pkg.sv
hw/dircc_status_register.sv
hw/dircc_edge_memory.sv
hw/dircc_host_port.sv
hw/dircc_update_engine.sv
hw/dircc_node.sv
testbench/tb_dircc_node.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_dircc_node -f src.f -o sim_dircc
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_dircc > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
